// ==== issue_stage_top.f ====
hdl/ooo_pkg.sv
hdl/rs_dispatch_if.sv
hdl/rs_dispatch.sv
hdl/reservation_station.sv
hdl/issue_stage_top.sv
verif/issue_stage_asserts.sv
verif/issue_stage_tb.sv

// ==== verif/issue_stage_tb.sv ====
`timescale 1ns/1ps

module issue_stage_tb;
    import ooo_pkg::*;

    localparam int RS_DEPTH     = 4;
    localparam int ROUTE_COUNT  = 10;
    localparam int RANDOM_COUNT = 60;
    localparam int TOTAL_INSTR  = ROUTE_COUNT + 3 + RS_DEPTH + 1 + RANDOM_COUNT;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_INSTR + 200;
    localparam int UNIT_ADD     = 0;
    localparam int UNIT_MUL     = 1;
    localparam int UNIT_DIV     = 2;

    typedef struct {
        logic [6:0]            opcode;
        logic [6:0]            funct7;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [PHYS_TAG_W-1:0] tag1;
        logic [PHYS_TAG_W-1:0] tag2;
        logic [1:0]            rdy;
        logic [PHYS_TAG_W-1:0] dest;
        add_payload_t          pay;  // func3 lives here
    } instr_t;

    typedef struct {
        int              unit;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        add_payload_t    pay;
        bit              woken;  // All waiting tags were broadcast
    } expect_t;

    logic clk, reset, in_valid, in_stall, cdb_valid;
    logic [6:0] in_opcode, in_funct7;
    logic [2:0] in_func3, add_func3, mul_func3, div_func3;
    logic [3:0] in_alu_op, add_alu_op;
    logic [1:0] in_src_ready;
    logic [XLEN-1:0] in_operand1, in_operand2, in_pc, in_immediate, cdb_data;
    logic [XLEN-1:0] add_operand1, add_operand2, add_immediate, add_pc;
    logic [XLEN-1:0] mul_operand1, mul_operand2, div_operand1, div_operand2;
    logic [PHYS_TAG_W-1:0] in_operand1_tag, in_operand2_tag, in_dest_tag, cdb_tag;
    logic [PHYS_TAG_W-1:0] add_dest_tag, mul_dest_tag, div_dest_tag;
    logic in_mem_to_reg, in_mem_read, in_mem_write, in_alu_src1, in_alu_src2;
    logic in_jump, in_branch, add_issue_valid, mul_issue_valid, div_issue_valid;
    logic add_alu_src1, add_alu_src2, add_mem_to_reg, add_mem_read, add_mem_write;
    logic add_jump, add_branch;
    add_payload_t add_issue_pay;

    instr_t                exp_ins [256];  // Indexed by destination tag
    string                 exp_test [256];
    bit [255:0]            exp_pending;
    bit [255:0]            cdb_seen;
    logic [XLEN-1:0]       cdb_hist [256];
    logic [PHYS_TAG_W-1:0] pending_tags [$];
    logic [PHYS_TAG_W-1:0] next_src_tag = 8'd1;
    logic [PHYS_TAG_W-1:0] next_dest = 8'd0;
    bit                    cdb_random_on;
    int                    outstanding;
    int                    value_errors;
    int                    other_errors;
    int                    cycle_count;

    issue_stage_top #(.RS_DEPTH(RS_DEPTH)) u_dut (.*);

    assign add_issue_pay = {add_func3, add_alu_op, add_alu_src1, add_alu_src2, add_mem_to_reg,
                            add_mem_read, add_mem_write, add_jump, add_branch, add_immediate,
                            add_pc};

    always #5 clk = ~clk;

    function automatic logic [16:0] route_case(input int i);
        case (i)
            0:       return {OPC_OP, F7_MULDIV, F3_MUL};
            1:       return {OPC_OP, F7_MULDIV, F3_DIV};
            2:       return {OPC_OP, F7_MULDIV, F3_REM};
            3:       return {OPC_OP, F7_MULDIV, 3'b001};      // MULH stays on add
            4:       return {OPC_OP, 7'b0000000, 3'b000};
            5:       return {OPC_OP, 7'b0100000, 3'b000};     // SUB
            6:       return {OPC_OP, 7'b0000000, 3'b100};     // XOR shares the DIV func3
            7:       return {7'b0010011, F7_MULDIV, 3'b000};  // ADDI
            8:       return {7'b0000011, 7'b0000000, 3'b010}; // LW
            default: return {7'b1100011, 7'b0000000, 3'b000};
        endcase
    endfunction

    function automatic instr_t make_instr(input logic [6:0] opc, input logic [6:0] f7,
                                          input logic [2:0] f3, input logic [1:0] rdy);
        instr_t     ins;
        logic [95:0] r;
        r          = {$urandom, $urandom, $urandom};
        ins.opcode = opc;
        ins.funct7 = f7;
        ins.pay    = r[$bits(add_payload_t)-1:0];
        ins.pay.func3 = f3;
        ins.op1    = $urandom;
        ins.op2    = $urandom;
        ins.rdy    = rdy;
        ins.tag1   = PHYS_TAG_W'($urandom);
        ins.tag2   = PHYS_TAG_W'($urandom);
        if (!rdy[0]) begin
            ins.tag1 = next_src_tag;  // Fresh tag that was never broadcast
            next_src_tag++;
        end
        if (!rdy[1]) begin
            ins.tag2 = next_src_tag;
            next_src_tag++;
        end
        ins.dest = next_dest;
        next_dest++;
        return ins;
    endfunction

    function automatic instr_t random_instr();
        logic [6:0] opc;
        logic [6:0] f7;
        logic [1:0] rdy;
        opc = ($urandom_range(1) == 1) ? OPC_OP : 7'($urandom);
        f7  = ($urandom_range(1) == 1) ? F7_MULDIV : 7'($urandom);
        rdy = {$urandom_range(2) != 0, $urandom_range(2) != 0};
        return make_instr(opc, f7, 3'($urandom), rdy);
    endfunction

    // Reference model for routing and operand values
    function automatic expect_t expected_issue(input instr_t ins);
        expect_t e;
        e.unit = UNIT_ADD;
        if (ins.opcode == OPC_OP && ins.funct7 == F7_MULDIV) begin
            if (ins.pay.func3 == F3_MUL) begin
                e.unit = UNIT_MUL;
            end else if (ins.pay.func3 == F3_DIV || ins.pay.func3 == F3_REM) begin
                e.unit = UNIT_DIV;
            end
        end
        e.op1   = ins.rdy[0] ? ins.op1 : cdb_hist[ins.tag1];
        e.op2   = ins.rdy[1] ? ins.op2 : cdb_hist[ins.tag2];
        e.pay   = ins.pay;
        e.woken = (ins.rdy[0] || cdb_seen[ins.tag1]) && (ins.rdy[1] || cdb_seen[ins.tag2]);
        return e;
    endfunction

    task automatic drive_inputs(input instr_t ins, input logic valid);
        in_valid        = valid;
        in_opcode       = ins.opcode;
        in_funct7       = ins.funct7;
        in_func3        = ins.pay.func3;
        in_operand1     = ins.op1;
        in_operand2     = ins.op2;
        in_operand1_tag = ins.tag1;
        in_operand2_tag = ins.tag2;
        in_src_ready    = ins.rdy;
        in_dest_tag     = ins.dest;
        in_alu_op       = ins.pay.alu_op;
        in_alu_src1     = ins.pay.alu_src1;
        in_alu_src2     = ins.pay.alu_src2;
        in_mem_to_reg   = ins.pay.mem_to_reg;
        in_mem_read     = ins.pay.mem_read;
        in_mem_write    = ins.pay.mem_write;
        in_jump         = ins.pay.jump;
        in_branch       = ins.pay.branch;
        in_immediate    = ins.pay.immediate;
        in_pc           = ins.pay.pc;
    endtask

    // Called just after a falling edge and returns at the falling edge after acceptance
    task automatic dispatch(input instr_t ins, input string test);
        drive_inputs(ins, 1'b1);
        #1;
        while (in_stall) begin
            @(negedge clk);
            #1;
        end
        exp_ins[ins.dest]     = ins;
        exp_test[ins.dest]    = test;
        exp_pending[ins.dest] = 1'b1;
        outstanding++;
        if (cdb_random_on && !ins.rdy[0]) pending_tags.push_back(ins.tag1);
        if (cdb_random_on && !ins.rdy[1]) pending_tags.push_back(ins.tag2);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic put_on_cdb(input logic [PHYS_TAG_W-1:0] tag);
        cdb_valid      = 1'b1;
        cdb_tag        = tag;
        cdb_data       = $urandom;
        cdb_hist[tag]  = cdb_data;
        cdb_seen[tag]  = 1'b1;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // Room for a stray issue to show up
    endtask

    task automatic check_issue(input int unit, input logic [XLEN-1:0] op1,
                               input logic [XLEN-1:0] op2, input logic [PHYS_TAG_W-1:0] dest,
                               input logic [2:0] func3, input add_payload_t pay);
        expect_t e;
        string   t;
        assert (exp_pending[dest]) else begin
            other_errors++;
            $display("ERROR: unit %0d issued dest tag %0d, which is not waiting", unit, dest);
        end
        if (exp_pending[dest]) begin
            e = expected_issue(exp_ins[dest]);
            t = exp_test[dest];
            exp_pending[dest] = 1'b0;
            outstanding--;
            assert (e.woken) else begin
                other_errors++;
                $display("ERROR: %s dest tag %0d issued before its operands were broadcast",
                         t, dest);
            end
            assert (e.unit == unit) else begin
                value_errors++;
                $display("FAILED %s: unit expected %0d actual %0d", t, e.unit, unit);
            end
            assert (e.op1 == op1) else begin
                value_errors++;
                $display("FAILED %s: operand1 expected %h actual %h", t, e.op1, op1);
            end
            assert (e.op2 == op2) else begin
                value_errors++;
                $display("FAILED %s: operand2 expected %h actual %h", t, e.op2, op2);
            end
            assert (e.pay.func3 == func3) else begin
                value_errors++;
                $display("FAILED %s: func3 expected %h actual %h", t, e.pay.func3, func3);
            end
            assert (unit != UNIT_ADD || e.pay == pay) else begin
                value_errors++;
                $display("FAILED %s: add payload expected %h actual %h", t, e.pay, pay);
            end
        end
    endtask

    task automatic finish_run();
        $display("Error counts: %0d value mismatches, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Random CDB traffic over tags of accepted instructions
    always @(negedge clk) begin
        int idx;
        if (cdb_random_on) begin
            if (pending_tags.size() > 0 && $urandom_range(2) == 0) begin
                idx = $urandom_range(pending_tags.size() - 1);
                put_on_cdb(pending_tags[idx]);
                pending_tags.delete(idx);
            end else begin
                cdb_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (add_issue_valid) begin
                check_issue(UNIT_ADD, add_operand1, add_operand2, add_dest_tag, add_func3,
                            add_issue_pay);
            end
            if (mul_issue_valid) begin
                check_issue(UNIT_MUL, mul_operand1, mul_operand2, mul_dest_tag, mul_func3, '0);
            end
            if (div_issue_valid) begin
                check_issue(UNIT_DIV, div_operand1, div_operand2, div_dest_tag, div_func3, '0);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        other_errors++;
        $display("ERROR: timeout after %0d cycles, %0d instructions never issued",
                 cycle_count, outstanding);
        finish_run();
    end

    initial begin
        instr_t                ins;
        logic [16:0]           rc;
        logic [PHYS_TAG_W-1:0] shared_tag;
        void'($urandom(32'h67d2_354d));
        clk       = 1'b0;
        reset     = 1'b1;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_data  = '0;
        ins       = '{default: '0};
        drive_inputs(ins, 1'b0);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        assert (!add_issue_valid && !mul_issue_valid && !div_issue_valid && !in_stall) else begin
            value_errors++;
            $display("FAILED reset: issue valids and in_stall expected 0000 actual %b%b%b%b",
                     add_issue_valid, mul_issue_valid, div_issue_valid, in_stall);
        end

        for (int i = 0; i < ROUTE_COUNT; i++) begin
            rc = route_case(i);
            dispatch(make_instr(rc[16:10], rc[9:3], rc[2:0], 2'b11), "routing");
        end
        wait_drain();

        ins = make_instr(OPC_OP, F7_MULDIV, F3_MUL, 2'b01);  // Operand 2 waits
        dispatch(ins, "wakeup later");
        repeat (3) @(negedge clk);
        put_on_cdb(ins.tag2);
        @(negedge clk);
        cdb_valid = 1'b0;
        ins = make_instr(OPC_OP, 7'b0000000, 3'b000, 2'b10);
        put_on_cdb(ins.tag1);  // Same edge as the dispatch
        dispatch(ins, "wakeup same cycle");
        cdb_valid = 1'b0;
        ins = make_instr(OPC_OP, F7_MULDIV, F3_REM, 2'b00);
        put_on_cdb(ins.tag1);
        dispatch(ins, "wakeup both");
        cdb_valid = 1'b0;
        repeat (2) @(negedge clk);
        put_on_cdb(ins.tag2);
        @(negedge clk);
        cdb_valid = 1'b0;
        wait_drain();

        ins = make_instr(OPC_OP, F7_MULDIV, F3_DIV, 2'b10);
        shared_tag = ins.tag1;
        dispatch(ins, "backpressure");
        for (int j = 1; j < RS_DEPTH; j++) begin
            ins      = make_instr(OPC_OP, F7_MULDIV, F3_DIV, 2'b11);
            ins.rdy  = 2'b10;
            ins.tag1 = shared_tag;
            dispatch(ins, "backpressure");
        end
        ins = make_instr(OPC_OP, F7_MULDIV, F3_DIV, 2'b01);
        drive_inputs(ins, 1'b1);
        #1;
        assert (in_stall) else begin
            value_errors++;
            $display("FAILED backpressure: in_stall expected 1 actual %b", in_stall);
        end
        @(negedge clk);
        in_valid = 1'b0;
        put_on_cdb(shared_tag);
        @(negedge clk);
        cdb_valid = 1'b0;
        dispatch(ins, "backpressure");
        put_on_cdb(ins.tag2);
        @(negedge clk);
        cdb_valid = 1'b0;
        wait_drain();

        cdb_random_on = 1'b1;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            dispatch(random_instr(), "random");
        end
        wait_drain();
        finish_run();
    end

endmodule

// ==== verif/issue_stage_asserts.sv ====
`timescale 1ns/1ps

module issue_stage_asserts #(
    parameter int RS_DEPTH = 4
) (
    input logic                clk,
    input logic                reset,
    input logic                in_valid,
    input logic                in_stall,
    input logic                add_issue_valid,
    input logic                mul_issue_valid,
    input logic                div_issue_valid,
    input logic [RS_DEPTH-1:0] add_entries,
    input logic [RS_DEPTH-1:0] mul_entries,
    input logic [RS_DEPTH-1:0] div_entries
);

    assert property (@(posedge clk)
        $past(reset) |-> !(add_issue_valid || mul_issue_valid || div_issue_valid))
        else $error("Issue valid high in the cycle after reset");

    // An issue comes from a slot that was valid one edge earlier
    assert property (@(posedge clk) disable iff (reset) add_issue_valid |-> $past(|add_entries))
        else $error("Add station issued while empty");
    assert property (@(posedge clk) disable iff (reset) mul_issue_valid |-> $past(|mul_entries))
        else $error("Mul station issued while empty");
    assert property (@(posedge clk) disable iff (reset) div_issue_valid |-> $past(|div_entries))
        else $error("Div station issued while empty");

    assert property (@(posedge clk) !in_valid |-> !in_stall)
        else $error("in_stall high with in_valid low");

endmodule

bind issue_stage_top issue_stage_asserts #(.RS_DEPTH(RS_DEPTH)) u_asserts (
    .clk             (clk),
    .reset           (reset),
    .in_valid        (in_valid),
    .in_stall        (in_stall),
    .add_issue_valid (add_issue_valid),
    .mul_issue_valid (mul_issue_valid),
    .div_issue_valid (div_issue_valid),
    .add_entries     (u_add_rs.entry_valid),
    .mul_entries     (u_mul_rs.entry_valid),
    .div_entries     (u_div_rs.entry_valid)
);

// ==== hdl/issue_stage_top.sv ====
`timescale 1ns/1ps

module issue_stage_top #(
    parameter int RS_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [6:0]                     in_opcode,
    input  logic [2:0]                     in_func3,
    input  logic [6:0]                     in_funct7,
    input  logic [ooo_pkg::XLEN-1:0]       in_operand1,
    input  logic [ooo_pkg::XLEN-1:0]       in_operand2,
    input  logic [ooo_pkg::XLEN-1:0]       in_pc,
    input  logic [ooo_pkg::XLEN-1:0]       in_immediate,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_operand1_tag,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_operand2_tag,
    input  logic [1:0]                     in_src_ready,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_dest_tag,
    input  logic                           in_mem_to_reg,
    input  logic                           in_mem_read,
    input  logic                           in_mem_write,
    input  logic [3:0]                     in_alu_op,
    input  logic                           in_alu_src1,
    input  logic                           in_alu_src2,
    input  logic                           in_jump,
    input  logic                           in_branch,
    output logic                           in_stall,
    input  logic                           cdb_valid,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] cdb_tag,
    input  logic [ooo_pkg::XLEN-1:0]       cdb_data,
    output logic                           add_issue_valid,
    output logic [ooo_pkg::XLEN-1:0]       add_operand1,
    output logic [ooo_pkg::XLEN-1:0]       add_operand2,
    output logic [ooo_pkg::PHYS_TAG_W-1:0] add_dest_tag,
    output logic [2:0]                     add_func3,
    output logic [3:0]                     add_alu_op,
    output logic                           add_alu_src1,
    output logic                           add_alu_src2,
    output logic                           add_mem_to_reg,
    output logic                           add_mem_read,
    output logic                           add_mem_write,
    output logic                           add_jump,
    output logic                           add_branch,
    output logic [ooo_pkg::XLEN-1:0]       add_immediate,
    output logic [ooo_pkg::XLEN-1:0]       add_pc,
    output logic                           mul_issue_valid,
    output logic [ooo_pkg::XLEN-1:0]       mul_operand1,
    output logic [ooo_pkg::XLEN-1:0]       mul_operand2,
    output logic [ooo_pkg::PHYS_TAG_W-1:0] mul_dest_tag,
    output logic [2:0]                     mul_func3,
    output logic                           div_issue_valid,
    output logic [ooo_pkg::XLEN-1:0]       div_operand1,
    output logic [ooo_pkg::XLEN-1:0]       div_operand2,
    output logic [ooo_pkg::PHYS_TAG_W-1:0] div_dest_tag,
    output logic [2:0]                     div_func3
);
    import ooo_pkg::*;

    add_payload_t    add_issue_payload;
    muldiv_payload_t mul_issue_payload;
    muldiv_payload_t div_issue_payload;

    rs_dispatch_if #(.payload_t(add_payload_t))    add_if ();
    rs_dispatch_if #(.payload_t(muldiv_payload_t)) mul_if ();
    rs_dispatch_if #(.payload_t(muldiv_payload_t)) div_if ();

    rs_dispatch u_dispatch (
        .in_valid        (in_valid),
        .in_opcode       (in_opcode),
        .in_func3        (in_func3),
        .in_funct7       (in_funct7),
        .in_operand1     (in_operand1),
        .in_operand2     (in_operand2),
        .in_pc           (in_pc),
        .in_immediate    (in_immediate),
        .in_operand1_tag (in_operand1_tag),
        .in_operand2_tag (in_operand2_tag),
        .in_src_ready    (in_src_ready),
        .in_dest_tag     (in_dest_tag),
        .in_mem_to_reg   (in_mem_to_reg),
        .in_mem_read     (in_mem_read),
        .in_mem_write    (in_mem_write),
        .in_alu_op       (in_alu_op),
        .in_alu_src1     (in_alu_src1),
        .in_alu_src2     (in_alu_src2),
        .in_jump         (in_jump),
        .in_branch       (in_branch),
        .in_stall        (in_stall),
        .add_rs          (add_if.decoder),
        .mul_rs          (mul_if.decoder),
        .div_rs          (div_if.decoder)
    );

    reservation_station #(.payload_t(add_payload_t), .RS_DEPTH(RS_DEPTH)) u_add_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (add_if.station),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .issue_valid    (add_issue_valid),
        .issue_operand1 (add_operand1),
        .issue_operand2 (add_operand2),
        .issue_dest_tag (add_dest_tag),
        .issue_payload  (add_issue_payload)
    );

    reservation_station #(.payload_t(muldiv_payload_t), .RS_DEPTH(RS_DEPTH)) u_mul_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (mul_if.station),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .issue_valid    (mul_issue_valid),
        .issue_operand1 (mul_operand1),
        .issue_operand2 (mul_operand2),
        .issue_dest_tag (mul_dest_tag),
        .issue_payload  (mul_issue_payload)
    );

    reservation_station #(.payload_t(muldiv_payload_t), .RS_DEPTH(RS_DEPTH)) u_div_rs (
        .clk            (clk),
        .reset          (reset),
        .disp           (div_if.station),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .issue_valid    (div_issue_valid),
        .issue_operand1 (div_operand1),
        .issue_operand2 (div_operand2),
        .issue_dest_tag (div_dest_tag),
        .issue_payload  (div_issue_payload)
    );

    assign add_func3      = add_issue_payload.func3;
    assign add_alu_op     = add_issue_payload.alu_op;
    assign add_alu_src1   = add_issue_payload.alu_src1;
    assign add_alu_src2   = add_issue_payload.alu_src2;
    assign add_mem_to_reg = add_issue_payload.mem_to_reg;
    assign add_mem_read   = add_issue_payload.mem_read;
    assign add_mem_write  = add_issue_payload.mem_write;
    assign add_jump       = add_issue_payload.jump;
    assign add_branch     = add_issue_payload.branch;
    assign add_immediate  = add_issue_payload.immediate;
    assign add_pc         = add_issue_payload.pc;
    assign mul_func3      = mul_issue_payload.func3;
    assign div_func3      = div_issue_payload.func3;

endmodule

// ==== hdl/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station #(
    parameter type payload_t = ooo_pkg::add_payload_t,
    parameter int  RS_DEPTH  = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    rs_dispatch_if.station                 disp,
    input  logic                           cdb_valid,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] cdb_tag,
    input  logic [ooo_pkg::XLEN-1:0]       cdb_data,
    output logic                           issue_valid,
    output logic [ooo_pkg::XLEN-1:0]       issue_operand1,
    output logic [ooo_pkg::XLEN-1:0]       issue_operand2,
    output logic [ooo_pkg::PHYS_TAG_W-1:0] issue_dest_tag,
    output payload_t                       issue_payload
);
    import ooo_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    logic [RS_DEPTH-1:0]   entry_valid;
    logic [XLEN-1:0]       op_val   [RS_DEPTH][2];
    logic [PHYS_TAG_W-1:0] op_tag   [RS_DEPTH][2];
    logic [1:0]            op_rdy   [RS_DEPTH];
    logic [PHYS_TAG_W-1:0] dest_tag [RS_DEPTH];
    payload_t              payload  [RS_DEPTH];

    logic                  free_found;
    logic [IDX_W-1:0]      free_idx;
    logic                  ready_found;
    logic [IDX_W-1:0]      ready_idx;
    logic                  dispatch_write;
    logic [XLEN-1:0]       in_val [2];
    logic [PHYS_TAG_W-1:0] in_tag [2];
    logic [1:0]            in_rdy;

    // Lowest free slot for writes, lowest complete slot for issue
    always_comb begin
        free_found  = 1'b0;
        free_idx    = '0;
        ready_found = 1'b0;
        ready_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
            if (entry_valid[i] && (op_rdy[i] == 2'b11) && !ready_found) begin
                ready_found = 1'b1;
                ready_idx   = IDX_W'(i);
            end
        end
    end

    assign disp.full      = !free_found;
    assign dispatch_write = disp.valid && free_found;

    assign in_tag[0] = disp.src1_tag;
    assign in_tag[1] = disp.src2_tag;

    // Incoming operands snoop the CDB in the same cycle
    always_comb begin
        in_val[0] = disp.src1_val;
        in_val[1] = disp.src2_val;
        in_rdy    = disp.src_ready;
        for (int k = 0; k < 2; k++) begin
            if (cdb_valid && !in_rdy[k] && (in_tag[k] == cdb_tag)) begin
                in_val[k] = cdb_data;
                in_rdy[k] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= ready_found;
            if (ready_found) begin
                entry_valid[ready_idx] <= 1'b0;
            end
            if (dispatch_write) begin
                entry_valid[free_idx] <= 1'b1;  // Never the issuing slot
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (entry_valid[i] && cdb_valid && !op_rdy[i][k] &&
                    (op_tag[i][k] == cdb_tag)) begin
                    op_val[i][k] <= cdb_data;
                    op_rdy[i][k] <= 1'b1;
                end
            end
        end
        if (dispatch_write) begin
            op_val[free_idx][0] <= in_val[0];
            op_val[free_idx][1] <= in_val[1];
            op_tag[free_idx][0] <= in_tag[0];
            op_tag[free_idx][1] <= in_tag[1];
            op_rdy[free_idx]    <= in_rdy;
            dest_tag[free_idx]  <= disp.dest_tag;
            payload[free_idx]   <= disp.payload;
        end
        if (ready_found) begin
            issue_operand1 <= op_val[ready_idx][0];
            issue_operand2 <= op_val[ready_idx][1];
            issue_dest_tag <= dest_tag[ready_idx];
            issue_payload  <= payload[ready_idx];
        end
    end

endmodule

// ==== hdl/rs_dispatch.sv ====
`timescale 1ns/1ps

module rs_dispatch (
    input  logic                           in_valid,
    input  logic [6:0]                     in_opcode,
    input  logic [2:0]                     in_func3,
    input  logic [6:0]                     in_funct7,
    input  logic [ooo_pkg::XLEN-1:0]       in_operand1,
    input  logic [ooo_pkg::XLEN-1:0]       in_operand2,
    input  logic [ooo_pkg::XLEN-1:0]       in_pc,
    input  logic [ooo_pkg::XLEN-1:0]       in_immediate,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_operand1_tag,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_operand2_tag,
    input  logic [1:0]                     in_src_ready,
    input  logic [ooo_pkg::PHYS_TAG_W-1:0] in_dest_tag,
    input  logic                           in_mem_to_reg,
    input  logic                           in_mem_read,
    input  logic                           in_mem_write,
    input  logic [3:0]                     in_alu_op,
    input  logic                           in_alu_src1,
    input  logic                           in_alu_src2,
    input  logic                           in_jump,
    input  logic                           in_branch,
    output logic                           in_stall,
    rs_dispatch_if.decoder                 add_rs,
    rs_dispatch_if.decoder                 mul_rs,
    rs_dispatch_if.decoder                 div_rs
);
    import ooo_pkg::*;

    logic is_muldiv;
    logic to_mul;
    logic to_div;
    logic to_add;
    add_payload_t    add_payload;
    muldiv_payload_t muldiv_payload;

    assign is_muldiv = (in_opcode == OPC_OP) && (in_funct7 == F7_MULDIV);
    assign to_mul    = is_muldiv && (in_func3 == F3_MUL);
    assign to_div    = is_muldiv && ((in_func3 == F3_DIV) || (in_func3 == F3_REM));
    assign to_add    = !to_mul && !to_div;  // Everything else lands in the add station

    always_comb begin
        add_payload.func3      = in_func3;
        add_payload.alu_op     = in_alu_op;
        add_payload.alu_src1   = in_alu_src1;
        add_payload.alu_src2   = in_alu_src2;
        add_payload.mem_to_reg = in_mem_to_reg;
        add_payload.mem_read   = in_mem_read;
        add_payload.mem_write  = in_mem_write;
        add_payload.jump       = in_jump;
        add_payload.branch     = in_branch;
        add_payload.immediate  = in_immediate;
        add_payload.pc         = in_pc;
        muldiv_payload.func3   = in_func3;
    end

    // Operand fields fan out to all stations, valid selects the one that writes
    assign add_rs.valid     = in_valid && to_add;
    assign add_rs.src1_val  = in_operand1;
    assign add_rs.src2_val  = in_operand2;
    assign add_rs.src1_tag  = in_operand1_tag;
    assign add_rs.src2_tag  = in_operand2_tag;
    assign add_rs.src_ready = in_src_ready;
    assign add_rs.dest_tag  = in_dest_tag;
    assign add_rs.payload   = add_payload;

    assign mul_rs.valid     = in_valid && to_mul;
    assign mul_rs.src1_val  = in_operand1;
    assign mul_rs.src2_val  = in_operand2;
    assign mul_rs.src1_tag  = in_operand1_tag;
    assign mul_rs.src2_tag  = in_operand2_tag;
    assign mul_rs.src_ready = in_src_ready;
    assign mul_rs.dest_tag  = in_dest_tag;
    assign mul_rs.payload   = muldiv_payload;

    assign div_rs.valid     = in_valid && to_div;
    assign div_rs.src1_val  = in_operand1;
    assign div_rs.src2_val  = in_operand2;
    assign div_rs.src1_tag  = in_operand1_tag;
    assign div_rs.src2_tag  = in_operand2_tag;
    assign div_rs.src_ready = in_src_ready;
    assign div_rs.dest_tag  = in_dest_tag;
    assign div_rs.payload   = muldiv_payload;

    assign in_stall = in_valid && ((to_add && add_rs.full) ||
                                   (to_mul && mul_rs.full) ||
                                   (to_div && div_rs.full));

endmodule

// ==== hdl/rs_dispatch_if.sv ====
`timescale 1ns/1ps

interface rs_dispatch_if #(
    parameter type payload_t = ooo_pkg::add_payload_t
) ();
    import ooo_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       src1_val;
    logic [XLEN-1:0]       src2_val;
    logic [PHYS_TAG_W-1:0] src1_tag;
    logic [PHYS_TAG_W-1:0] src2_tag;
    logic [1:0]            src_ready;  // Bit 0 is operand 1
    logic [PHYS_TAG_W-1:0] dest_tag;
    payload_t              payload;
    logic                  full;       // No free slot in the station

    modport decoder (
        output valid, src1_val, src2_val, src1_tag, src2_tag,
        output src_ready, dest_tag, payload,
        input  full
    );

    modport station (
        input  valid, src1_val, src2_val, src1_tag, src2_tag,
        input  src_ready, dest_tag, payload,
        output full
    );

endinterface

// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int PHYS_TAG_W = 8;

    localparam logic [6:0] OPC_OP    = 7'b0110011;  // R-type
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_MUL = 3'b000;
    localparam logic [2:0] F3_DIV = 3'b100;
    localparam logic [2:0] F3_REM = 3'b110;

    // ALU and memory control travel with the add station only
    typedef struct packed {
        logic [2:0]      func3;
        logic [3:0]      alu_op;
        logic            alu_src1;
        logic            alu_src2;
        logic            mem_to_reg;
        logic            mem_read;
        logic            mem_write;
        logic            jump;
        logic            branch;
        logic [XLEN-1:0] immediate;
        logic [XLEN-1:0] pc;
    } add_payload_t;

    typedef struct packed {
        logic [2:0] func3;  // Selects MUL, DIV or REM
    } muldiv_payload_t;

endpackage
